//--- logic/io_board_pkg.sv
// io board shared definitions
// widths, menu key and command codes, SPI opcodes and FSM state types
package io_board_pkg;

    // ******************************
    // widths that carry a meaning
    // ******************************
    typedef logic [11:0] joy_t;         // bit 0 left, 1 right, 2 down, 3 up, 4..6 fire
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] status_t;
    typedef logic [24:0] ioctl_addr_t;
    typedef logic [4:0]  menu_key_t;
    typedef logic [2:0]  menu_cmd_t;

    // ******************************
    // menu key byte encoding
    // ******************************
    localparam menu_key_t key_left   = 5'd27;
    localparam menu_key_t key_right  = 5'd23;
    localparam menu_key_t key_down   = 5'd29;
    localparam menu_key_t key_up     = 5'd30;
    localparam menu_key_t key_return = 5'd15;
    localparam menu_key_t key_none   = 5'd31;

    localparam menu_cmd_t cmd_nop = 3'd7;
    localparam menu_cmd_t cmd_osd = 3'd3;

    localparam byte_t key_byte_idle    = 8'hff;  // power-up hold-off
    localparam byte_t key_byte_no_core = 8'h3f;  // nothing downloaded yet

    // opcodes sent by the menu microcontroller as the first byte of a frame
    localparam byte_t op_status_wr = 8'h14;
    localparam byte_t op_dl_start  = 8'h54;
    localparam byte_t op_dl_data   = 8'h55;
    localparam byte_t op_dl_end    = 8'h56;

    // ******************************
    // state machines
    // ******************************
    typedef enum logic [1:0] {scan_load, scan_sample, scan_shift} scan_state_t;

    typedef enum logic [2:0] {spi_cmd, spi_status, spi_index, spi_data, spi_ignore} spi_state_t;

endpackage

//--- logic/joy_scanner.sv
// DB9 joystick scanner
// clocks both joysticks out of the external shift register, one step per line tick
`timescale 1ns/10ps

module joy_scanner
    import io_board_pkg::*;
(
    input  logic clk_sys,
    input  logic arst_n,
    input  logic hs,        // one-cycle line tick
    input  logic joy_data,  // active low serial data
    output logic joy_clk,
    output logic joy_load,
    output joy_t joystick1,
    output joy_t joystick2
);

    localparam int unsigned NUM_BITS = 24;

    scan_state_t state;
    logic [4:0]  bit_cnt;           // bit being read, 0 to 23
    logic [23:0] shift_q;           // collected bits, first bit ends up at position 0
    logic        publish;           // scan complete, copy to outputs next cycle

    // ******************************
    // scan sequencer
    // ******************************
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            state    <= scan_load;
            bit_cnt  <= '0;
            joy_clk  <= 1'b0;
            joy_load <= 1'b0;
            publish  <= 1'b0;
        end else begin
            publish <= 1'b0;
            if (hs) begin
                case (state)
                    scan_load: begin
                        joy_load <= 1'b1;   // register captures the buttons
                        joy_clk  <= 1'b0;
                        bit_cnt  <= '0;
                        state    <= scan_sample;
                    end
                    scan_sample: begin
                        joy_load <= 1'b0;
                        joy_clk  <= 1'b1;   // data sampled now, next bit after this edge
                        if (bit_cnt == 5'(NUM_BITS - 1)) begin
                            publish <= 1'b1;
                        end
                        state <= scan_shift;
                    end
                    scan_shift: begin
                        joy_clk <= 1'b0;
                        if (bit_cnt == 5'(NUM_BITS - 1)) begin
                            state <= scan_load;
                        end else begin
                            bit_cnt <= bit_cnt + 5'd1;
                            state   <= scan_sample;
                        end
                    end
                    default: state <= scan_load;
                endcase
            end
        end
    end

    // the line is active low, store pressed buttons as ones
    always_ff @(posedge clk_sys) begin
        if (hs && state == scan_sample) begin
            shift_q <= {~joy_data, shift_q[23:1]};
        end
    end

    // ******************************
    // output words
    // ******************************
    // both players change on the same cycle so no partial scan is ever visible
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            joystick1 <= '0;
            joystick2 <= '0;
        end else if (publish) begin
            joystick1 <= shift_q[11:0];
            joystick2 <= shift_q[23:12];
        end
    end

endmodule

//--- logic/host_spi_link.sv
// SPI slave towards the menu microcontroller
// takes the status word and ROM downloads, answers every byte with the key byte
`timescale 1ns/10ps

module host_spi_link
    import io_board_pkg::*;
(
    input  logic        clk_sys,
    input  logic        arst_n,
    input  logic        spi_sck,
    input  logic        spi_ss_n,
    input  logic        spi_di,
    input  byte_t       key_byte,
    output logic        spi_do,
    output status_t     status,
    output logic [6:0]  core_mod,
    output logic        ioctl_download,
    output byte_t       ioctl_index,
    output logic        ioctl_wr,
    output ioctl_addr_t ioctl_addr,
    output byte_t       ioctl_dout
);

    logic sck_meta, sck_s, sck_d;
    logic ss_meta, ss_s, ss_d;
    logic di_meta, di_s;

    logic       sck_rise, sck_fall;
    logic       frame_open;
    logic [2:0] bit_cnt;
    logic [6:0] rx_sr;
    byte_t      rx_byte;
    logic       byte_done;
    logic [6:0] tx_sr;

    spi_state_t  state;
    logic [1:0]  status_idx;
    logic [23:0] status_buf;      // first three status bytes, LSB first

    // ******************************
    // input synchronizers
    // ******************************
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            sck_meta <= 1'b0;
            sck_s    <= 1'b0;
            sck_d    <= 1'b0;
            ss_meta  <= 1'b1;
            ss_s     <= 1'b1;
            ss_d     <= 1'b1;
            di_meta  <= 1'b0;
            di_s     <= 1'b0;
        end else begin
            sck_meta <= spi_sck;
            sck_s    <= sck_meta;
            sck_d    <= sck_s;
            ss_meta  <= spi_ss_n;
            ss_s     <= ss_meta;
            ss_d     <= ss_s;
            di_meta  <= spi_di;
            di_s     <= di_meta;
        end
    end

    assign sck_rise   = sck_s & ~sck_d & ~ss_s;
    assign sck_fall   = ~sck_s & sck_d & ~ss_s;
    assign frame_open = ss_d & ~ss_s;

    // ******************************
    // receive side, MSB first
    // ******************************
    assign rx_byte   = {rx_sr, di_s};
    assign byte_done = sck_rise && (bit_cnt == 3'd7);

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            bit_cnt <= '0;
        end else if (ss_s) begin
            bit_cnt <= '0;              // every frame starts byte aligned
        end else if (sck_rise) begin
            bit_cnt <= bit_cnt + 3'd1;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (sck_rise) begin
            rx_sr <= rx_byte[6:0];
        end
    end

    // ******************************
    // transmit side
    // ******************************
    // key_byte is taken when a frame opens and on the falling edge after each full byte
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            spi_do <= 1'b1;
            tx_sr  <= '1;
        end else if (ss_s) begin
            spi_do <= 1'b1;
        end else if (frame_open || (sck_fall && bit_cnt == 3'd0)) begin
            spi_do <= key_byte[7];
            tx_sr  <= key_byte[6:0];
        end else if (sck_fall) begin
            spi_do <= tx_sr[6];
            tx_sr  <= {tx_sr[5:0], 1'b1};
        end
    end

    // ******************************
    // command decoder
    // ******************************
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            state          <= spi_cmd;
            status_idx     <= '0;
            status         <= '0;
            core_mod       <= '0;
            ioctl_download <= 1'b0;
            ioctl_wr       <= 1'b0;
            ioctl_addr     <= '0;
        end else begin
            ioctl_wr <= 1'b0;
            if (ioctl_wr) begin
                ioctl_addr <= ioctl_addr + 25'd1;   // advance once the write is out
            end
            if (ss_s) begin
                state <= spi_cmd;
            end else if (byte_done) begin
                case (state)
                    spi_cmd: begin
                        status_idx <= '0;
                        case (rx_byte)
                            op_status_wr: state <= spi_status;
                            op_dl_start:  state <= spi_index;
                            op_dl_data:   state <= spi_data;
                            op_dl_end: begin
                                ioctl_download <= 1'b0;
                                state          <= spi_ignore;
                            end
                            default:      state <= spi_ignore;
                        endcase
                    end
                    spi_status: begin
                        status_idx <= status_idx + 2'd1;
                        if (status_idx == 2'd3) begin
                            status   <= {rx_byte, status_buf};
                            core_mod <= status_buf[6:0];
                            state    <= spi_ignore;
                        end
                    end
                    spi_index: begin
                        ioctl_addr     <= '0;
                        ioctl_download <= 1'b1;
                        state          <= spi_ignore;
                    end
                    spi_data: ioctl_wr <= 1'b1;
                    default: ;                          // rest of the frame is dropped
                endcase
            end
        end
    end

    // payload registers for the status bytes and the download port
    always_ff @(posedge clk_sys) begin
        if (byte_done) begin
            if (state == spi_status && status_idx != 2'd3) begin
                status_buf[8*status_idx +: 8] <= rx_byte;
            end
            if (state == spi_index) begin
                ioctl_index <= rx_byte;
            end
            if (state == spi_data) begin
                ioctl_dout <= rx_byte;
            end
        end
    end

endmodule

//--- logic/menu_key_encoder.sv
// menu key encoder
// turns the joysticks and download history into the byte returned on the SPI link
`timescale 1ns/10ps

module menu_key_encoder
    import io_board_pkg::*;
#(
    parameter int unsigned STRETCH_TICKS  = 4,
    parameter int unsigned HOLDOFF_CYCLES = 65535
) (
    input  logic  clk_sys,
    input  logic  arst_n,
    input  logic  hs,
    input  joy_t  joystick1,
    input  joy_t  joystick2,
    input  logic  ioctl_download,
    output byte_t key_byte
);

    localparam int unsigned STRETCH_W = $clog2(STRETCH_TICKS + 1);
    localparam int unsigned HOLDOFF_W = $clog2(HOLDOFF_CYCLES + 1);

    logic [6:0]           joy_mix;
    logic                 chord;
    menu_key_t            key_code;
    menu_cmd_t            cmd_code;
    logic [STRETCH_W-1:0] stretch_cnt;
    logic [HOLDOFF_W-1:0] holdoff_cnt;
    logic                 dl_seen;

    // either player can drive the menu
    assign joy_mix = joystick1[6:0] | joystick2[6:0];
    assign chord   = &joy_mix[6:4];     // three fire buttons together open the OSD

    always_comb begin
        if (joy_mix[0]) begin
            key_code = key_left;
        end else if (joy_mix[1]) begin
            key_code = key_right;
        end else if (joy_mix[2]) begin
            key_code = key_down;
        end else if (joy_mix[3]) begin
            key_code = key_up;
        end else if (joy_mix[4]) begin
            key_code = key_return;
        end else begin
            key_code = key_none;
        end
    end

    // ******************************
    // chord stretch on line ticks
    // ******************************
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            stretch_cnt <= '0;
        end else if (chord) begin
            stretch_cnt <= STRETCH_W'(STRETCH_TICKS);
        end else if (hs && stretch_cnt != '0) begin
            stretch_cnt <= stretch_cnt - 1'b1;
        end
    end

    assign cmd_code = (stretch_cnt != '0) ? cmd_osd : cmd_nop;

    // ******************************
    // key byte register
    // ******************************
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            holdoff_cnt <= HOLDOFF_W'(HOLDOFF_CYCLES);
            dl_seen     <= 1'b0;
            key_byte    <= key_byte_idle;
        end else begin
            if (ioctl_download) begin
                dl_seen <= 1'b1;    // sticky, a core has been loaded
            end
            if (holdoff_cnt != '0) begin
                holdoff_cnt <= holdoff_cnt - 1'b1;
                key_byte    <= key_byte_idle;
            end else if (!dl_seen) begin
                key_byte <= key_byte_no_core;
            end else begin
                key_byte <= {cmd_code, key_code};
            end
        end
    end

endmodule

//--- logic/io_board_top.sv
// io board top level
// joystick scanner, SPI link to the menu controller and the key encoder between them
`timescale 1ns/10ps

module io_board_top
    import io_board_pkg::*;
#(
    parameter int unsigned STRETCH_TICKS  = 4,       // hs ticks the menu chord is held
    parameter int unsigned HOLDOFF_CYCLES = 65535    // idle key bytes after reset
) (
    input  logic        clk_sys,
    input  logic        arst_n,
    input  logic        hs,
    // DB9 shift register
    input  logic        joy_data,
    output logic        joy_clk,
    output logic        joy_load,
    output joy_t        joystick1,
    output joy_t        joystick2,
    // menu microcontroller
    input  logic        spi_sck,
    input  logic        spi_ss_n,
    input  logic        spi_di,
    output logic        spi_do,
    output status_t     status,
    output logic [6:0]  core_mod,
    // ROM download port
    output logic        ioctl_download,
    output byte_t       ioctl_index,
    output logic        ioctl_wr,
    output ioctl_addr_t ioctl_addr,
    output byte_t       ioctl_dout
);

    byte_t key_byte;    // answer byte for the next SPI transfer

    joy_scanner joy_scanner_i (
        .clk_sys   (clk_sys),
        .arst_n    (arst_n),
        .hs        (hs),
        .joy_data  (joy_data),
        .joy_clk   (joy_clk),
        .joy_load  (joy_load),
        .joystick1 (joystick1),
        .joystick2 (joystick2)
    );

    host_spi_link host_spi_link_i (
        .clk_sys        (clk_sys),
        .arst_n         (arst_n),
        .spi_sck        (spi_sck),
        .spi_ss_n       (spi_ss_n),
        .spi_di         (spi_di),
        .key_byte       (key_byte),
        .spi_do         (spi_do),
        .status         (status),
        .core_mod       (core_mod),
        .ioctl_download (ioctl_download),
        .ioctl_index    (ioctl_index),
        .ioctl_wr       (ioctl_wr),
        .ioctl_addr     (ioctl_addr),
        .ioctl_dout     (ioctl_dout)
    );

    menu_key_encoder #(
        .STRETCH_TICKS  (STRETCH_TICKS),
        .HOLDOFF_CYCLES (HOLDOFF_CYCLES)
    ) menu_key_encoder_i (
        .clk_sys        (clk_sys),
        .arst_n         (arst_n),
        .hs             (hs),
        .joystick1      (joystick1),
        .joystick2      (joystick2),
        .ioctl_download (ioctl_download),
        .key_byte       (key_byte)
    );

endmodule

//--- tests/io_board_tb.sv
// io board testbench
// joystick shift register model, SPI master and a reference model of the key byte
`timescale 1ns/10ps

module io_board_tb
    import io_board_pkg::*;
;

    localparam int unsigned STRETCH_TICKS  = 4;
    localparam int unsigned HOLDOFF_CYCLES = 200;
    localparam int unsigned SEED           = 94480;
    localparam int unsigned TIMEOUT_CYCLES = 60000;
    localparam int          DL_BYTES       = 20;

    logic clk_sys  = 1'b0;
    logic arst_n   = 1'b0;
    logic hs       = 1'b0;
    logic joy_data = 1'b1;
    logic spi_sck  = 1'b0;
    logic spi_ss_n = 1'b1;
    logic spi_di   = 1'b0;

    logic        joy_clk, joy_load, spi_do;
    joy_t        joystick1, joystick2;
    status_t     status;
    logic [6:0]  core_mod;
    logic        ioctl_download, ioctl_wr;
    byte_t       ioctl_index, ioctl_dout;
    ioctl_addr_t ioctl_addr;

    joy_t        joy1_val = '0;    // buttons held on the two DB9 ports
    joy_t        joy2_val = '0;
    logic [23:0] sr_model = '0;
    logic        joy_clk_d = 1'b0;
    logic [3:0]  hs_div = '0;
    int unsigned cycle_cnt = 0;
    int          wr_count = 0;
    byte_t       dl_bytes [0:DL_BYTES-1];

    io_board_top #(
        .STRETCH_TICKS  (STRETCH_TICKS),
        .HOLDOFF_CYCLES (HOLDOFF_CYCLES)
    ) io_board_top_i (
        .clk_sys (clk_sys), .arst_n (arst_n), .hs (hs),
        .joy_data (joy_data), .joy_clk (joy_clk), .joy_load (joy_load),
        .joystick1 (joystick1), .joystick2 (joystick2),
        .spi_sck (spi_sck), .spi_ss_n (spi_ss_n), .spi_di (spi_di), .spi_do (spi_do),
        .status (status), .core_mod (core_mod),
        .ioctl_download (ioctl_download), .ioctl_index (ioctl_index), .ioctl_wr (ioctl_wr),
        .ioctl_addr (ioctl_addr), .ioctl_dout (ioctl_dout)
    );

    always #50 clk_sys = ~clk_sys;

    // line tick, one cycle in ten
    always @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            hs_div <= '0;
            hs     <= 1'b0;
        end else if (hs_div == 4'd9) begin
            hs_div <= '0;
            hs     <= 1'b1;
        end else begin
            hs_div <= hs_div + 4'd1;
            hs     <= 1'b0;
        end
    end

    // ******************************
    // DB9 shift register model
    // ******************************
    always @(posedge clk_sys) begin
        joy_clk_d <= joy_clk;
        if (joy_load) begin
            sr_model <= {joy2_val, joy1_val};           // player 1 bit 0 comes out first
        end else if (joy_clk && !joy_clk_d) begin
            sr_model <= {1'b0, sr_model[23:1]};
        end
        joy_data <= ~sr_model[0];   // pressed button pulls the line low
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        stop_on_error($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    always @(posedge clk_sys) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            stop_on_error("timeout, the tests did not finish within the cycle limit");
        end
    end

    // every write strobe must carry the next byte at the next address
    always @(posedge clk_sys) begin
        if (ioctl_wr) begin
            assert (wr_count < DL_BYTES) else stop_on_error("more write strobes than bytes sent");
            assert (ioctl_download) else stop_on_error("write strobe outside of a download");
            assert (ioctl_dout == dl_bytes[wr_count])
                else report_mismatch("ioctl_dout", 32'(ioctl_dout), 32'(dl_bytes[wr_count]));
            assert (ioctl_addr == 25'(wr_count))
                else report_mismatch("ioctl_addr", 32'(ioctl_addr), 32'(wr_count));
            wr_count <= wr_count + 1;
        end
    end

    // expected key byte from the joystick words and download history
    function automatic byte_t key_ref(input joy_t joy1, input joy_t joy2,
                                      input bit downloaded, input bit chord_active);
        logic [6:0] mix;
        menu_key_t  key;
        menu_cmd_t  cmd;
        if (!downloaded) begin
            return 8'h3f;
        end
        mix = joy1[6:0] | joy2[6:0];
        if (mix[0]) begin
            key = key_left;
        end else if (mix[1]) begin
            key = key_right;
        end else if (mix[2]) begin
            key = key_down;
        end else if (mix[3]) begin
            key = key_up;
        end else if (mix[4]) begin
            key = key_return;
        end else begin
            key = key_none;
        end
        cmd = chord_active ? cmd_osd : cmd_nop;
        return {cmd, key};
    endfunction

    // ******************************
    // SPI master, mode 0
    // ******************************
    task automatic frame_start();
        @(posedge clk_sys);
        spi_ss_n <= 1'b0;
    endtask

    task automatic xfer_byte(input byte_t tx, output byte_t rx);
        for (int i = 7; i >= 0; i--) begin
            @(posedge clk_sys);
            spi_sck <= 1'b0;
            spi_di  <= tx[i];
            repeat (4) @(posedge clk_sys);
            rx[i] = spi_do;           // slave output settled since the falling edge
            spi_sck <= 1'b1;
            repeat (3) @(posedge clk_sys);
        end
    endtask

    task automatic frame_end();
        @(posedge clk_sys);
        spi_sck <= 1'b0;
        repeat (4) @(posedge clk_sys);
        spi_ss_n <= 1'b1;
        repeat (8) @(posedge clk_sys);
    endtask

    task automatic read_key(output byte_t rx);
        frame_start();
        xfer_byte(8'h00, rx);         // unknown opcode, only the answer matters
        frame_end();
    endtask

    task automatic wait_ticks(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(posedge clk_sys);
            if (hs) begin
                seen++;
            end
        end
    endtask

    initial begin
        joy_t  j1, j2;
        joy_t  low_mask;
        int    lvl;
        byte_t rx, idx, exp;
        byte_t st [0:3];
        void'($urandom(SEED));
        repeat (8) @(posedge clk_sys);
        arst_n <= 1'b1;
        @(posedge clk_sys);
        assert (!joy_clk && !joy_load) else stop_on_error("joystick lines not idle after reset");
        assert (!ioctl_wr && !ioctl_download)
            else stop_on_error("download port not idle after reset");
        assert (spi_do) else report_mismatch("spi_do", 32'(spi_do), 32'h1);
        assert (status == '0) else report_mismatch("status", 32'(status), 32'h0);
        assert (core_mod == '0) else report_mismatch("core_mod", 32'(core_mod), 32'h0);
        assert (ioctl_addr == '0) else report_mismatch("ioctl_addr", 32'(ioctl_addr), 32'h0);
        assert (joystick1 == '0) else report_mismatch("joystick1", 32'(joystick1), 32'h0);
        assert (joystick2 == '0) else report_mismatch("joystick2", 32'(joystick2), 32'h0);
        read_key(rx);
        assert (rx == 8'hff) else report_mismatch("spi_do byte", 32'(rx), 32'hff);
        repeat (HOLDOFF_CYCLES) @(posedge clk_sys);
        read_key(rx);
        exp = key_ref('0, '0, 1'b0, 1'b0);
        assert (rx == exp) else report_mismatch("spi_do byte", 32'(rx), 32'(exp));

        // ******************************
        // joystick scan
        // ******************************
        for (int n = 0; n < 10; n++) begin
            j1 = 12'($urandom);
            j2 = 12'($urandom);
            joy1_val <= j1;
            joy2_val <= j2;
            wait_ticks(100);
            assert (joystick1 == j1) else report_mismatch("joystick1", 32'(joystick1), 32'(j1));
            assert (joystick2 == j2) else report_mismatch("joystick2", 32'(joystick2), 32'(j2));
        end

        // status word, least significant byte first
        // every byte of the frame answers with the no-core key byte
        exp = key_ref('0, '0, 1'b0, 1'b0);
        frame_start();
        xfer_byte(op_status_wr, rx);
        assert (rx == exp) else report_mismatch("spi_do byte", 32'(rx), 32'(exp));
        for (int i = 0; i < 4; i++) begin
            st[i] = 8'($urandom);
            xfer_byte(st[i], rx);
            assert (rx == exp) else report_mismatch("spi_do byte", 32'(rx), 32'(exp));
        end
        frame_end();
        assert (status == {st[3], st[2], st[1], st[0]})
            else report_mismatch("status", 32'(status), {st[3], st[2], st[1], st[0]});
        assert (core_mod == st[0][6:0])
            else report_mismatch("core_mod", 32'(core_mod), 32'(st[0][6:0]));

        // ******************************
        // ROM download
        // ******************************
        idx = 8'($urandom);
        frame_start();
        xfer_byte(op_dl_start, rx);
        xfer_byte(idx, rx);
        frame_end();
        assert (ioctl_download) else stop_on_error("download did not start");
        assert (ioctl_index == idx) else report_mismatch("ioctl_index", 32'(ioctl_index), 32'(idx));
        for (int i = 0; i < DL_BYTES; i++) begin
            dl_bytes[i] = 8'($urandom);
        end
        frame_start();
        xfer_byte(op_dl_data, rx);
        for (int i = 0; i < DL_BYTES; i++) begin
            xfer_byte(dl_bytes[i], rx);
        end
        frame_end();
        frame_start();
        xfer_byte(op_dl_end, rx);
        frame_end();
        assert (!ioctl_download) else stop_on_error("download did not end");
        assert (wr_count == DL_BYTES)
            else report_mismatch("ioctl_wr count", 32'(wr_count), 32'(DL_BYTES));

        // key encoding without the chord, the stretch must have run out before the read
        for (int n = 0; n < 8; n++) begin
            j1 = 12'($urandom);
            j2 = 12'($urandom);
            // each pass clears the higher priority keys so every key code shows up
            lvl = n % 6;
            low_mask = 12'((1 << lvl) - 1);
            j1 = j1 & ~low_mask;
            j2 = j2 & ~low_mask;
            if (lvl < 5) begin
                j1[lvl] = 1'b1;
            end
            if (&(j1[6:4] | j2[6:4])) begin
                j1[6] = 1'b0;
                j2[6] = 1'b0;
            end
            joy1_val <= j1;
            joy2_val <= j2;
            wait_ticks(100 + STRETCH_TICKS + 2);
            read_key(rx);
            exp = key_ref(j1, j2, 1'b1, 1'b0);
            assert (rx == exp) else report_mismatch("spi_do byte", 32'(rx), 32'(exp));
        end

        // ******************************
        // menu chord
        // ******************************
        j1 = 12'h071;                 // three fire buttons and left
        joy1_val <= j1;
        joy2_val <= '0;
        wait_ticks(100);
        read_key(rx);
        exp = key_ref(j1, '0, 1'b1, 1'b1);
        assert (rx == exp) else report_mismatch("spi_do byte", 32'(rx), 32'(exp));
        j1 = 12'h001;
        joy1_val <= j1;
        while (joystick1 != j1) begin
            @(posedge clk_sys);
        end
        wait_ticks(STRETCH_TICKS + 51);
        read_key(rx);
        exp = key_ref(j1, '0, 1'b1, 1'b0);
        assert (rx == exp) else report_mismatch("spi_do byte", 32'(rx), 32'(exp));

        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- vlog.f
logic/io_board_pkg.sv
logic/joy_scanner.sv
logic/host_spi_link.sv
logic/menu_key_encoder.sv
logic/io_board_top.sv
tests/io_board_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := io_board_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
